// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_actionpoint
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/ap_checker.sv ====
/*
 * actionpoint checker
 * reference model of the unit that compares the UUT ports on every rising edge
 */
`timescale 1ns/1ns
`default_nettype none

module ap_checker
   import ap_regs_pkg::*;
   import ap_match_pkg::*;
(
   input  wire logic                  clk_debug,
   input  wire logic                  rst_a,
   input  wire logic                  i_en,
   input  wire logic                  i_actionhalt,
   input  wire logic                  i_aux_write,
   input  wire logic                  i_aux_read,
   input  wire logic [AUX_ADDR_W-1:0] i_aux_addr,
   input  wire logic [DATA_W-1:0]     i_aux_data,
   input  wire logic                  i_h_write,
   input  wire logic [AUX_ADDR_W-1:0] i_h_addr,
   input  wire logic [DATA_W-1:0]     i_h_data,
   input  wire logic [AUX_ADDR_W-1:0] i_rd_addr,
   input  wire logic [PC_W-1:0]       i_pc,
   input  wire logic                  i_pc_valid,
   input  wire logic [DATA_W-1:0]     i_mem_addr,
   input  wire logic                  i_mload,
   input  wire logic                  i_mstore,
   input  wire logic [DATA_W-1:0]     i_store_data,
   input  wire logic [DATA_W-1:0]     o_rd_data,   // UUT outputs to watch
   input  wire logic                  o_brk,
   input  wire logic                  o_swi,
   input  wire logic [NUM_APS-1:0]    o_status,
   output int                         o_errors
);

   logic [DATA_W-1:0]  m_value [NUM_APS];   // model registers
   logic [DATA_W-1:0]  m_mask  [NUM_APS];
   logic [AC_W-1:0]    m_ctrl  [NUM_APS];
   logic [NUM_APS-1:0] m_status;
   int                 mismatches = 0;
   int                 test_start = 0;      // mismatch count when the test began
   int                 tests_run  = 0;
   int                 tests_bad  = 0;

   assign o_errors = mismatches;

   // watched bus for one actionpoint
   function automatic logic [DATA_W-1:0] source_of(input int i);
      case (m_ctrl[i][AC_TARGET_LSB +: 2])
         TGT_PC:         return i_pc;
         TGT_MEM_ADDR:   return i_mem_addr;
         TGT_STORE_DATA: return i_store_data;
         default:        return {{(DATA_W-AUX_ADDR_W){1'b0}}, i_aux_addr};
      endcase
   endfunction

   function automatic logic strobe_of(input int i);
      case (m_ctrl[i][AC_TARGET_LSB +: 2])
         TGT_PC:         return i_pc_valid;
         TGT_MEM_ADDR:   return i_mload | i_mstore;   // loads and stores
         TGT_STORE_DATA: return i_mstore;
         default:        return i_aux_read | i_aux_write;
      endcase
   endfunction

   // expected qualified hits after pairing
   function automatic logic [NUM_APS-1:0] qualified_hits();
      logic [NUM_APS-1:0] raw;
      logic [NUM_APS-1:0] qual;
      logic [1:0]         mode;
      logic               same;
      int                 prev;
      int                 nxt;
      for (int i = 0; i < NUM_APS; i++)
      begin
         mode   = m_ctrl[i][AC_MODE_LSB +: 2];
         same   = ((source_of(i) ^ m_value[i]) & ~m_mask[i]) == '0;   // mask 1 = ignore
         raw[i] = i_en && strobe_of(i) &&
                  ((mode == MODE_EQ && same) || (mode == MODE_NE && !same));
      end
      for (int i = 0; i < NUM_APS; i++)
      begin
         prev = (i == 0) ? NUM_APS - 1 : i - 1;
         nxt  = (i == NUM_APS - 1) ? 0 : i + 1;   // last pairs with first
         if (m_ctrl[prev][AC_PAIR])
            qual[i] = 1'b0;   // second half of a pair
         else if (m_ctrl[i][AC_PAIR])
            qual[i] = raw[i] & raw[nxt];
         else
            qual[i] = raw[i];
      end
      return qual;
   endfunction

   function automatic logic [DATA_W-1:0] expected_read(input logic [AUX_ADDR_W-1:0] addr);
      int off;
      off = int'(addr) - int'(AP_AUX_BASE);
      if (off < 0 || off >= 3 * NUM_APS)
         return '0;   // outside the map
      case (off % 3)
         AP_REG_VALUE: return m_value[off / 3];
         AP_REG_MASK:  return m_mask[off / 3];
         default:      return {{(DATA_W-AC_W){1'b0}}, m_ctrl[off / 3]};
      endcase
   endfunction

   task automatic store_reg(input logic [AUX_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            inout logic [NUM_APS-1:0] written);
      int off;
      off = int'(addr) - int'(AP_AUX_BASE);
      if (off >= 0 && off < 3 * NUM_APS)
      begin
         written[off / 3] = 1'b1;   // clears that ap's status
         case (off % 3)
            AP_REG_VALUE: m_value[off / 3] = data;
            AP_REG_MASK:  m_mask[off / 3]  = data;
            default:      m_ctrl[off / 3]  = data[AC_W-1:0];
         endcase
      end
   endtask

   task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
      if (got !== exp)
      begin
         $display("FAIL %s got %h expected %h at %0t ns", name, got, exp, $time);
         mismatches++;
      end
   endtask

   always @(posedge clk_debug or posedge rst_a)
   begin : compare_edge
      logic [NUM_APS-1:0] qual;
      logic [NUM_APS-1:0] written;
      logic               exp_brk;
      logic               exp_swi;
      int                 cap;
      if (rst_a)
      begin
         for (int i = 0; i < NUM_APS; i++)
         begin
            m_value[i] = '0;
            m_mask[i]  = '0;
            m_ctrl[i]  = '0;
         end
         m_status = '0;
      end
      else
      begin
         qual    = qualified_hits();
         exp_brk = 1'b0;
         exp_swi = 1'b0;
         cap     = -1;
         for (int i = NUM_APS - 1; i >= 0; i--)
         begin
            if (qual[i])
            begin
               if (m_ctrl[i][AC_ACTION])
                  exp_swi = 1'b1;
               else
                  exp_brk = 1'b1;
               cap = i;   // ends on the lowest index
            end
         end
         check_value("o_brk", DATA_W'(o_brk), DATA_W'(exp_brk));
         check_value("o_swi", DATA_W'(o_swi), DATA_W'(exp_swi));
         check_value("o_status", DATA_W'(o_status), DATA_W'(m_status));
         check_value("o_rd_data", o_rd_data, expected_read(i_rd_addr));
         // model update for the next edge in capture > host > core order
         written = '0;
         if (cap >= 0 && !i_actionhalt)
         begin
            m_value[cap] = source_of(cap);
            written[cap] = 1'b1;
         end
         else if (i_h_write && i_en)
            store_reg(i_h_addr, i_h_data, written);
         else if (i_aux_write)
            store_reg(i_aux_addr, i_aux_data, written);
         m_status = (m_status & ~written) | qual;   // hit wins over clear
      end
   end

   task automatic end_test(input string name);
      tests_run++;
      if (mismatches != test_start)
      begin
         tests_bad++;
         $display("test %0d %s: %0d mismatches", tests_run, name, mismatches - test_start);
      end
      else
         $display("test %0d %s: ok", tests_run, name);
      test_start = mismatches;
   endtask

   task automatic report();
      $display("tests run %0d, tests with errors %0d, mismatches %0d",
               tests_run, tests_bad, mismatches);
   endtask

endmodule

`default_nettype wire

// ==== bench/tb_actionpoint.sv ====
/*
 * actionpoint unit testbench
 * clock, reset, LFSR stimulus and watchdog around the UUT and its checker
 */
`timescale 1ns/1ns
`default_nettype none

module tb_actionpoint
   import ap_regs_pkg::*;
   import ap_match_pkg::*;
();

   localparam int PERIOD      = 100;
   // reset, readback, priority, 8 match rounds, 2 pairs, status
   localparam int TEST_CYCLES = 5 + 34 + 4 + 8 * 9 + 2 * 11 + 15;
   localparam int WATCHDOG_NS = (TEST_CYCLES + 100) * PERIOD;  // plus margin

   logic                  clk_debug;
   logic                  rst_a;
   logic                  i_en;
   logic                  i_actionhalt;
   logic                  i_aux_write;
   logic                  i_aux_read;
   logic [AUX_ADDR_W-1:0] i_aux_addr;
   logic [DATA_W-1:0]     i_aux_data;
   logic                  i_h_write;
   logic [AUX_ADDR_W-1:0] i_h_addr;
   logic [DATA_W-1:0]     i_h_data;
   logic [AUX_ADDR_W-1:0] i_rd_addr;
   logic [PC_W-1:0]       i_pc;
   logic                  i_pc_valid;
   logic [DATA_W-1:0]     i_mem_addr;
   logic                  i_mload;
   logic                  i_mstore;
   logic [DATA_W-1:0]     i_store_data;
   logic [DATA_W-1:0]     o_rd_data;
   logic                  o_brk;
   logic                  o_swi;
   logic [NUM_APS-1:0]    o_status;
   int                    errors;
   logic [31:0]           lfsr;
   logic [AUX_ADDR_W-1:0] addr;
   logic [DATA_W-1:0]     value;
   int                    idx;

   actionpoint_unit UUT (.*);

   ap_checker chk (.*, .o_errors(errors));

   initial
   begin
      clk_debug = 1'b0;
      forever #(PERIOD / 2) clk_debug = ~clk_debug;
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns, stimulus did not finish", WATCHDOG_NS);
      $display("Test failed");
      $finish;
   end

   // fibonacci lfsr with taps 32 22 2 1
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int k = 0; k < n; k++)
      begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};   // one step per bit
         r    = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   function automatic logic [AUX_ADDR_W-1:0] reg_addr(input int ap, input int off);
      return AP_AUX_BASE + AUX_ADDR_W'(3 * ap + off);
   endfunction

   // step to the falling edge and drop all strobes
   task automatic next_cycle();
      @(negedge clk_debug);
      i_pc_valid  = 1'b0;
      i_mload     = 1'b0;
      i_mstore    = 1'b0;
      i_aux_read  = 1'b0;
      i_aux_write = 1'b0;
      i_h_write   = 1'b0;
   endtask

   task automatic host_write(input logic [AUX_ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
      next_cycle();
      i_h_write = 1'b1;
      i_h_addr  = a;
      i_h_data  = d;
   endtask

   task automatic core_write(input logic [AUX_ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
      next_cycle();
      i_aux_write = 1'b1;
      i_aux_addr  = a;
      i_aux_data  = d;
   endtask

   task automatic look(input logic [AUX_ADDR_W-1:0] a);
      next_cycle();
      i_rd_addr = a;
   endtask

   task automatic set_ap(input int ap, input logic [DATA_W-1:0] v, input logic [DATA_W-1:0] m,
                         input logic [AC_W-1:0] c);
      host_write(reg_addr(ap, AP_REG_VALUE), v);
      host_write(reg_addr(ap, AP_REG_MASK), m);
      host_write(reg_addr(ap, AP_REG_CTRL), DATA_W'(c));
   endtask

   // put v on one target bus with its strobe
   task automatic drive(input logic [1:0] tgt, input logic [DATA_W-1:0] v);
      case (tgt)
         TGT_PC:
         begin
            i_pc       = v;
            i_pc_valid = 1'b1;
         end
         TGT_MEM_ADDR:
         begin
            i_mem_addr = v;
            i_mload    = 1'b1;
         end
         TGT_STORE_DATA:
         begin
            i_store_data = v;
            i_mstore     = 1'b1;
         end
         default:
         begin
            i_aux_addr = v[AUX_ADDR_W-1:0];
            i_aux_read = 1'b1;   // read strobe so no register is written
         end
      endcase
   endtask

   initial
   begin
      lfsr         = 32'h2f8;
      rst_a        = 1'b1;
      i_en         = 1'b1;
      i_actionhalt = 1'b0;
      i_aux_write  = 1'b0;
      i_aux_read   = 1'b0;
      i_aux_addr   = '0;
      i_aux_data   = '0;
      i_h_write    = 1'b0;
      i_h_addr     = '0;
      i_h_data     = '0;
      i_rd_addr    = '0;
      i_pc         = '0;
      i_pc_valid   = 1'b0;
      i_mem_addr   = '0;
      i_mload      = 1'b0;
      i_mstore     = 1'b0;
      i_store_data = '0;
      repeat (5) @(negedge clk_debug);
      rst_a = 1'b0;

      // reset values then random core and host writes read back
      for (int a = 'h21f; a < 'h22d; a++)
         look(AUX_ADDR_W'(a));   // includes one unmapped address each side
      for (int k = 0; k < 8; k++)
      begin
         idx  = int'(rand_bits(2));
         addr = reg_addr(idx, int'(rand_bits(2) % 3));
         if (k % 2 == 1)
            host_write(addr, rand_bits(32));
         else
            core_write(addr, rand_bits(32));
         look(addr);
      end
      for (int i = 0; i < NUM_APS; i++)
         host_write(reg_addr(i, AP_REG_CTRL), '0);
      chk.end_test("register_readback");

      // host beats core and is ignored while i_en is low
      addr = reg_addr(1, AP_REG_MASK);
      core_write(addr, rand_bits(32));
      i_h_write = 1'b1;   // same cycle and register
      i_h_addr  = addr;
      i_h_data  = rand_bits(32);
      look(addr);
      i_en = 1'b0;
      host_write(addr, rand_bits(32));
      look(addr);
      i_en = 1'b1;
      chk.end_test("write_priority");

      // every target with both actions in eq then ne mode
      for (int t = 0; t < 4; t++)
      begin
         for (int act = 0; act < 2; act++)
         begin
            value = rand_bits(32);
            if (t == TGT_AUX_ADDR)
               value = value & 32'h0000_0fff;
            set_ap(t, value, 32'h0000_00f0, {1'b0, act[0], t[1:0], MODE_EQ});
            i_rd_addr = reg_addr(t, AP_REG_VALUE);
            next_cycle();
            drive(t[1:0], value ^ 32'h30);   // differs only under the mask
            next_cycle();
            i_en = 1'b0;
            drive(t[1:0], value);
            next_cycle();
            i_en = 1'b1;
            drive(t[1:0], value ^ 32'h1);   // unmasked mismatch
            host_write(reg_addr(t, AP_REG_CTRL), DATA_W'({1'b0, act[0], t[1:0], MODE_NE}));
            next_cycle();
            drive(t[1:0], value ^ 32'h100);
            host_write(reg_addr(t, AP_REG_CTRL), '0);
         end
      end
      chk.end_test("target_match");

      // pairs 1-2 and the wraparound 3-0
      for (int p = 1; p < NUM_APS; p += 2)
      begin
         idx   = (p + 1) % NUM_APS;
         value = rand_bits(32);
         set_ap(p, value, '0, {1'b1, 1'b0, TGT_PC, MODE_EQ});
         set_ap(idx, ~value, '0, {1'b0, 1'b1, TGT_MEM_ADDR, MODE_EQ});
         next_cycle();
         drive(TGT_PC, value);   // first half only
         next_cycle();
         drive(TGT_MEM_ADDR, ~value);   // second half only
         next_cycle();
         drive(TGT_PC, value);
         drive(TGT_MEM_ADDR, ~value);
         host_write(reg_addr(p, AP_REG_CTRL), '0);
         host_write(reg_addr(idx, AP_REG_CTRL), '0);
      end
      chk.end_test("pairing");

      // sticky status with capture blocked and then allowed
      value = rand_bits(32);
      set_ap(2, value, 32'h0000_00ff, {1'b0, 1'b0, TGT_STORE_DATA, MODE_EQ});
      i_rd_addr    = reg_addr(2, AP_REG_VALUE);
      i_actionhalt = 1'b1;
      next_cycle();
      drive(TGT_STORE_DATA, value ^ 32'h5a);
      repeat (3) next_cycle();
      i_actionhalt = 1'b0;
      drive(TGT_STORE_DATA, value ^ 32'h3c);   // captured
      repeat (2) next_cycle();
      host_write(reg_addr(2, AP_REG_MASK), 32'h0000_00ff);   // clears status
      next_cycle();
      drive(TGT_STORE_DATA, value ^ 32'h11);
      i_h_write = 1'b1;   // clear and hit together
      i_h_addr  = reg_addr(2, AP_REG_MASK);
      i_h_data  = 32'h0000_00ff;
      repeat (2) next_cycle();
      host_write(reg_addr(2, AP_REG_CTRL), '0);
      next_cycle();
      chk.end_test("status_capture");

      chk.report();
      if (errors == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== source/actionpoint_unit.sv ====
/*
 * actionpoint unit top
 * write arbiter, register bank, comparators and hit qualifier
 */
`timescale 1ns/1ns
`default_nettype none

module actionpoint_unit
   import ap_regs_pkg::*;
   import ap_match_pkg::*;
(
   input  wire logic                  clk_debug,
   input  wire logic                  rst_a,
   input  wire logic                  i_en,          // core running
   input  wire logic                  i_actionhalt,  // core halting
   input  wire logic                  i_aux_write,
   input  wire logic                  i_aux_read,
   input  wire logic [AUX_ADDR_W-1:0] i_aux_addr,
   input  wire logic [DATA_W-1:0]     i_aux_data,
   input  wire logic                  i_h_write,
   input  wire logic [AUX_ADDR_W-1:0] i_h_addr,
   input  wire logic [DATA_W-1:0]     i_h_data,
   input  wire logic [AUX_ADDR_W-1:0] i_rd_addr,
   input  wire logic [PC_W-1:0]       i_pc,
   input  wire logic                  i_pc_valid,
   input  wire logic [DATA_W-1:0]     i_mem_addr,
   input  wire logic                  i_mload,
   input  wire logic                  i_mstore,
   input  wire logic [DATA_W-1:0]     i_store_data,
   output logic [DATA_W-1:0]          o_rd_data,
   output logic                       o_brk,
   output logic                       o_swi,
   output logic [NUM_APS-1:0]         o_status
);

   logic                      wr_en;
   logic [AUX_ADDR_W-1:0]     wr_addr;
   logic [DATA_W-1:0]         wr_data;
   logic [NUM_APS*DATA_W-1:0] value, mask, source;
   logic [NUM_APS*AC_W-1:0]   ctrl;
   logic [NUM_APS-1:0]        written, raw_hit;
   logic                      cap_write;
   ap_idx_t                   cap_idx;
   logic [DATA_W-1:0]         cap_data;

   aux_write_arbiter u_arb (
      .i_cap_write(cap_write), .i_cap_idx(cap_idx), .i_cap_data(cap_data),
      .i_h_write(i_h_write), .i_h_addr(i_h_addr), .i_h_data(i_h_data), .i_en(i_en),
      .i_aux_write(i_aux_write), .i_aux_addr(i_aux_addr), .i_aux_data(i_aux_data),
      .o_wr_en(wr_en), .o_wr_addr(wr_addr), .o_wr_data(wr_data)
   );

   ap_register_bank u_bank (
      .clk_debug(clk_debug), .rst_a(rst_a),
      .i_wr_en(wr_en), .i_wr_addr(wr_addr), .i_wr_data(wr_data), .i_rd_addr(i_rd_addr),
      .o_value(value), .o_mask(mask), .o_ctrl(ctrl), .o_written(written),
      .o_rd_data(o_rd_data)
   );

   // one comparator per actionpoint, all share the observed buses
   for (genvar g = 0; g < NUM_APS; g++)
   begin : g_cmp
      ap_comparator u_cmp (
         .i_value(value[g*DATA_W +: DATA_W]), .i_mask(mask[g*DATA_W +: DATA_W]),
         .i_ctrl(ctrl[g*AC_W +: AC_W]),
         .i_pc(i_pc), .i_pc_valid(i_pc_valid),
         .i_mem_addr(i_mem_addr), .i_mload(i_mload), .i_mstore(i_mstore),
         .i_store_data(i_store_data),
         .i_aux_addr(i_aux_addr), .i_aux_read(i_aux_read), .i_aux_write(i_aux_write),
         .i_en(i_en),
         .o_hit(raw_hit[g]), .o_source(source[g*DATA_W +: DATA_W])
      );
   end

   ap_hit_qualifier u_qual (
      .clk_debug(clk_debug), .rst_a(rst_a),
      .i_raw_hit(raw_hit), .i_source(source), .i_ctrl(ctrl), .i_written(written),
      .i_actionhalt(i_actionhalt),
      .o_brk(o_brk), .o_swi(o_swi), .o_status(o_status),
      .o_cap_write(cap_write), .o_cap_idx(cap_idx), .o_cap_data(cap_data)
   );

endmodule

`default_nettype wire

// ==== source/ap_comparator.sv ====
/*
 * actionpoint comparator
 * picks the watched source and does the masked compare
 */
`timescale 1ns/1ns
`default_nettype none

module ap_comparator
   import ap_regs_pkg::*;
   import ap_match_pkg::*;
(
   input  wire logic [DATA_W-1:0]     i_value,
   input  wire logic [DATA_W-1:0]     i_mask,
   input  wire logic [AC_W-1:0]       i_ctrl,
   input  wire logic [PC_W-1:0]       i_pc,
   input  wire logic                  i_pc_valid,
   input  wire logic [DATA_W-1:0]     i_mem_addr,
   input  wire logic                  i_mload,
   input  wire logic                  i_mstore,
   input  wire logic [DATA_W-1:0]     i_store_data,
   input  wire logic [AUX_ADDR_W-1:0] i_aux_addr,
   input  wire logic                  i_aux_read,
   input  wire logic                  i_aux_write,
   input  wire logic                  i_en,
   output logic                       o_hit,
   output logic [DATA_W-1:0]          o_source    // value that gets captured
);

   logic [1:0] mode, target;
   logic       strobe;       // source valid this cycle
   logic       match;        // all unmasked bits equal
   logic       mode_hit;

   assign mode   = i_ctrl[AC_MODE_LSB +: 2];
   assign target = i_ctrl[AC_TARGET_LSB +: 2];

   always_comb
   begin
      case (target)
         TGT_PC:
         begin
            o_source = i_pc;
            strobe   = i_pc_valid;
         end
         TGT_MEM_ADDR:
         begin
            o_source = i_mem_addr;
            strobe   = i_mload | i_mstore;
         end
         TGT_STORE_DATA:
         begin
            o_source = i_store_data;
            strobe   = i_mstore;
         end
         TGT_AUX_ADDR:
         begin
            o_source = DATA_W'(i_aux_addr);   // zero-extend aux address
            strobe   = i_aux_read | i_aux_write;
         end
         default:
         begin
            o_source = '0;
            strobe   = 1'b0;
         end
      endcase
   end

   // mask bit set means ignore
   assign match = ((o_source ^ i_value) & ~i_mask) == '0;

   always_comb
   begin
      case (mode)
         MODE_EQ:  mode_hit = match;
         MODE_NE:  mode_hit = !match;
         MODE_OFF: mode_hit = 1'b0;
         default:  mode_hit = 1'b0;   // 3 is reserved and acts as off
      endcase
   end

   assign o_hit = i_en & strobe & mode_hit;

endmodule

`default_nettype wire

// ==== source/ap_hit_qualifier.sv ====
/*
 * actionpoint hit qualifier
 * pairing, break/swi split, sticky status and capture request
 */
`timescale 1ns/1ns
`default_nettype none

module ap_hit_qualifier
   import ap_regs_pkg::*;
(
   input  wire logic                      clk_debug,
   input  wire logic                      rst_a,
   input  wire logic [NUM_APS-1:0]        i_raw_hit,
   input  wire logic [NUM_APS*DATA_W-1:0] i_source,
   input  wire logic [NUM_APS*AC_W-1:0]   i_ctrl,
   input  wire logic [NUM_APS-1:0]        i_written,    // clears status
   input  wire logic                      i_actionhalt, // blocks capture
   output logic                           o_brk,
   output logic                           o_swi,
   output logic [NUM_APS-1:0]             o_status,
   output logic                           o_cap_write,
   output ap_idx_t                        o_cap_idx,
   output logic [DATA_W-1:0]              o_cap_data
);

   logic [NUM_APS-1:0] pair, action;   // per-ap control bits
   logic [NUM_APS-1:0] qual;           // hits after pairing
   logic [NUM_APS-1:0] status_r;

   always_comb
   begin
      for (int i = 0; i < NUM_APS; i++)
      begin
         pair[i]   = i_ctrl[i*AC_W + AC_PAIR];
         action[i] = i_ctrl[i*AC_W + AC_ACTION];
      end
      for (int i = 0; i < NUM_APS; i++)
      begin
         if (pair[(i + NUM_APS - 1) % NUM_APS])
            qual[i] = 1'b0;   // second of a pair never fires alone
         else if (pair[i])
            qual[i] = i_raw_hit[i] & i_raw_hit[(i + 1) % NUM_APS];   // wraps 3 -> 0
         else
            qual[i] = i_raw_hit[i];
      end
   end

   assign o_brk = |(qual & ~action);
   assign o_swi = |(qual & action);

   // sticky, a hit beats a same-cycle clear
   always_ff @(posedge clk_debug or posedge rst_a)
   begin
      if (rst_a)
         status_r <= '0;
      else
         status_r <= (status_r & ~i_written) | qual;
   end

   assign o_status = status_r;

   // lowest index wins, first ap of a pair is the qualified one
   always_comb
   begin
      o_cap_idx = '0;
      for (int i = NUM_APS - 1; i >= 0; i--)
         if (qual[i]) o_cap_idx = ap_idx_t'(i);
   end

   assign o_cap_write = |qual & ~i_actionhalt;   // no capture while halting
   assign o_cap_data  = i_source[o_cap_idx*DATA_W +: DATA_W];

endmodule

`default_nettype wire

// ==== source/ap_match_pkg.sv ====
/*
 * actionpoint match encodings
 * mode and target field values, pc width
 */
`default_nettype none

package ap_match_pkg;

   // mode field, value 3 is treated as off
   localparam logic [1:0] MODE_OFF = 2'd0;
   localparam logic [1:0] MODE_EQ  = 2'd1;   // masked equal
   localparam logic [1:0] MODE_NE  = 2'd2;   // masked not-equal

   // target field
   localparam logic [1:0] TGT_PC         = 2'd0;   // stage-2 pc
   localparam logic [1:0] TGT_MEM_ADDR   = 2'd1;   // ld/st address
   localparam logic [1:0] TGT_STORE_DATA = 2'd2;   // st write data
   localparam logic [1:0] TGT_AUX_ADDR   = 2'd3;   // lr/sr address

   localparam int PC_W = 32;

endpackage

`default_nettype wire

// ==== source/ap_register_bank.sv ====
/*
 * actionpoint register bank
 * value, mask and control per actionpoint, one write port, one read port
 */
`timescale 1ns/1ns
`default_nettype none

module ap_register_bank
   import ap_regs_pkg::*;
(
   input  wire logic                  clk_debug,
   input  wire logic                  rst_a,
   input  wire logic                  i_wr_en,
   input  wire logic [AUX_ADDR_W-1:0] i_wr_addr,
   input  wire logic [DATA_W-1:0]     i_wr_data,
   input  wire logic [AUX_ADDR_W-1:0] i_rd_addr,
   output logic [NUM_APS*DATA_W-1:0]  o_value,
   output logic [NUM_APS*DATA_W-1:0]  o_mask,
   output logic [NUM_APS*AC_W-1:0]    o_ctrl,
   output logic [NUM_APS-1:0]         o_written,   // any reg of ap i written
   output logic [DATA_W-1:0]          o_rd_data
);

   logic [DATA_W-1:0] value_r [NUM_APS];
   logic [DATA_W-1:0] mask_r  [NUM_APS];
   logic [AC_W-1:0]   ctrl_r  [NUM_APS];
   logic [NUM_APS-1:0] sel_v, sel_m, sel_c;   // write decode per ap

   always_comb
   begin
      for (int i = 0; i < NUM_APS; i++)
      begin
         sel_v[i] = i_wr_en && (i_wr_addr == ap_reg_addr(i, AP_REG_VALUE));
         sel_m[i] = i_wr_en && (i_wr_addr == ap_reg_addr(i, AP_REG_MASK));
         sel_c[i] = i_wr_en && (i_wr_addr == ap_reg_addr(i, AP_REG_CTRL));
      end
   end

   assign o_written = sel_v | sel_m | sel_c;   // same cycle as the write

   always_ff @(posedge clk_debug or posedge rst_a)
   begin
      if (rst_a)
      begin
         for (int i = 0; i < NUM_APS; i++)
         begin
            value_r[i] <= '0;
            mask_r[i]  <= '0;
            ctrl_r[i]  <= '0;
         end
      end
      else
      begin
         for (int i = 0; i < NUM_APS; i++)
         begin
            if (sel_v[i]) value_r[i] <= i_wr_data;
            if (sel_m[i]) mask_r[i]  <= i_wr_data;
            if (sel_c[i]) ctrl_r[i]  <= i_wr_data[AC_W-1:0];   // upper bits dropped
         end
      end
   end

   // flatten for the comparators, combinational readback
   always_comb
   begin
      o_rd_data = '0;   // unmapped reads zero
      for (int i = 0; i < NUM_APS; i++)
      begin
         o_value[i*DATA_W +: DATA_W] = value_r[i];
         o_mask[i*DATA_W +: DATA_W]  = mask_r[i];
         o_ctrl[i*AC_W +: AC_W]      = ctrl_r[i];
         if (i_rd_addr == ap_reg_addr(i, AP_REG_VALUE))
            o_rd_data = value_r[i];
         if (i_rd_addr == ap_reg_addr(i, AP_REG_MASK))
            o_rd_data = mask_r[i];
         if (i_rd_addr == ap_reg_addr(i, AP_REG_CTRL))
            o_rd_data = DATA_W'(ctrl_r[i]);   // zero-extended
      end
   end

endmodule

`default_nettype wire

// ==== source/ap_regs_pkg.sv ====
/*
 * actionpoint register map
 * address layout, data widths and control-word fields
 */
`default_nettype none

package ap_regs_pkg;

   localparam int NUM_APS    = 4;      // actionpoints in the unit
   localparam int AUX_ADDR_W = 12;     // aux register address bits
   localparam int DATA_W     = 32;     // aux data bits

   // actionpoint i sits at base + 3i, three registers each
   localparam logic [AUX_ADDR_W-1:0] AP_AUX_BASE = 12'h220;

   localparam int AP_REG_VALUE = 0;    // match value / captured value
   localparam int AP_REG_MASK  = 1;    // ignore mask, 1 = don't care
   localparam int AP_REG_CTRL  = 2;    // control word

   // control word layout
   localparam int AC_W          = 6;
   localparam int AC_MODE_LSB   = 0;   // bits 1:0
   localparam int AC_TARGET_LSB = 2;   // bits 3:2
   localparam int AC_ACTION     = 4;   // 0 break, 1 swi
   localparam int AC_PAIR       = 5;   // pair with next higher ap

   typedef logic [1:0] ap_idx_t;

   // aux address of one register of one actionpoint
   function automatic logic [AUX_ADDR_W-1:0] ap_reg_addr(input int unsigned idx,
                                                         input int unsigned off);
      return AUX_ADDR_W'(AP_AUX_BASE + 3 * idx + off);
   endfunction

endpackage

`default_nettype wire

// ==== source/aux_write_arbiter.sv ====
/*
 * aux write arbiter
 * picks one of capture, host or core writes for the register bank
 */
`timescale 1ns/1ns
`default_nettype none

module aux_write_arbiter
   import ap_regs_pkg::*;
(
   input  wire logic                  i_cap_write,   // hit capture strobe
   input  wire ap_idx_t               i_cap_idx,
   input  wire logic [DATA_W-1:0]     i_cap_data,
   input  wire logic                  i_h_write,     // debugger write
   input  wire logic [AUX_ADDR_W-1:0] i_h_addr,
   input  wire logic [DATA_W-1:0]     i_h_data,
   input  wire logic                  i_en,          // core running
   input  wire logic                  i_aux_write,   // core sr
   input  wire logic [AUX_ADDR_W-1:0] i_aux_addr,
   input  wire logic [DATA_W-1:0]     i_aux_data,
   output logic                       o_wr_en,
   output logic [AUX_ADDR_W-1:0]      o_wr_addr,
   output logic [DATA_W-1:0]          o_wr_data
);

   logic [AUX_ADDR_W-1:0] cap_addr;

   // capture always lands in the value register
   assign cap_addr = ap_reg_addr(i_cap_idx, AP_REG_VALUE);

   // capture > host > core, losers are dropped
   always_comb
   begin
      o_wr_en   = i_aux_write;   // core is the fall-through
      o_wr_addr = i_aux_addr;
      o_wr_data = i_aux_data;
      if (i_cap_write)
      begin
         o_wr_en   = 1'b1;
         o_wr_addr = cap_addr;
         o_wr_data = i_cap_data;
      end
      else if (i_h_write && i_en)   // host only counts while running
      begin
         o_wr_en   = 1'b1;
         o_wr_addr = i_h_addr;
         o_wr_data = i_h_data;
      end
   end

endmodule

`default_nettype wire

// ==== tb.f ====
source/ap_regs_pkg.sv
source/ap_match_pkg.sv
source/aux_write_arbiter.sv
source/ap_register_bank.sv
source/ap_comparator.sv
source/ap_hit_qualifier.sv
source/actionpoint_unit.sv
bench/ap_checker.sv
bench/tb_actionpoint.sv
